/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_mpram -f list.f -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* list.f */
verilog/mpram_pkg.sv
verilog/port_decode.sv
verilog/bank_array.sv
verilog/live_value_table.sv
verilog/read_select.sv
verilog/mpram_4w4r.sv
tests/tb_mpram.sv

/* tests/tb_mpram.sv */
`timescale 1ns/10ps

module tb_mpram import mpram_pkg::*; ();

	localparam int CLK_PERIOD      = 4;
	localparam int RESET_CYCLES    = 16;
	localparam int DIRECTED_CYCLES = 60;
	localparam int RANDOM_CYCLES   = 2000;
	localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 2;

	logic      clock;
	logic      rst_n;
	port_req_t req_0;
	port_req_t req_1;
	port_req_t req_2;
	port_req_t req_3;
	port_rsp_t rsp_0;
	port_rsp_t rsp_1;
	port_rsp_t rsp_2;
	port_rsp_t rsp_3;

	port_rsp_t            rsp [NUM_PORTS];
	port_req_t            next_req [NUM_PORTS];
	logic [DATA_BITS-1:0] model [MEM_DEPTH];
	logic                 exp_valid [NUM_PORTS];
	logic [DATA_BITS-1:0] exp_data [NUM_PORTS];
	int                   test_errors;
	int                   total_errors;
	int                   tests_run;
	int                   tests_failed;

	mpram_4w4r u_dut (
		.clock (clock),
		.rst_n (rst_n),
		.req_0 (req_0),
		.req_1 (req_1),
		.req_2 (req_2),
		.req_3 (req_3),
		.rsp_0 (rsp_0),
		.rsp_1 (rsp_1),
		.rsp_2 (rsp_2),
		.rsp_3 (rsp_3)
	);

	assign rsp[0] = rsp_0;
	assign rsp[1] = rsp_1;
	assign rsp[2] = rsp_2;
	assign rsp[3] = rsp_3;

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// Compare the outputs with what the requests of the previous cycle owe.
	task automatic check_responses();
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (rsp[p].rvalid !== exp_valid[p]) begin
				$display("FAILED rsp_%0d.rvalid expected %h got %h", p, exp_valid[p],
					rsp[p].rvalid);
				test_errors++;
			end
			if (rsp[p].rdata !== exp_data[p]) begin
				$display("FAILED rsp_%0d.rdata expected %h got %h", p, exp_data[p],
					rsp[p].rdata);
				test_errors++;
			end
		end
	endtask

	// Reads see the memory as it was before this cycle's writes, and a
	// writer gets its own data back. Writes land in port order so the
	// highest port wins an address.
	task automatic apply_requests();
		for (int p = 0; p < NUM_PORTS; p++) begin
			exp_valid[p] = (next_req[p].cmd != CMD_IDLE);
			if (next_req[p].cmd == CMD_WRITE) begin
				exp_data[p] = next_req[p].wdata;
			end else if (next_req[p].cmd == CMD_READ) begin
				exp_data[p] = model[next_req[p].addr];
			end else begin
				exp_data[p] = '0;
			end
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (next_req[p].cmd == CMD_WRITE) begin
				model[next_req[p].addr] = next_req[p].wdata;
			end
		end
		req_0 = next_req[0];
		req_1 = next_req[1];
		req_2 = next_req[2];
		req_3 = next_req[3];
	endtask

	task automatic step();
		@(negedge clock);
		check_responses();
		apply_requests();
	endtask

	task automatic clear_requests();
		for (int p = 0; p < NUM_PORTS; p++) begin
			next_req[p] = '{cmd: CMD_IDLE, addr: '0, wdata: '0};
		end
	endtask

	task automatic set_write(input int p, input int addr, input logic [DATA_BITS-1:0] data);
		next_req[p] = '{cmd: CMD_WRITE, addr: ADDR_BITS'(addr), wdata: data};
	endtask

	task automatic set_read(input int p, input int addr);
		next_req[p] = '{cmd: CMD_READ, addr: ADDR_BITS'(addr), wdata: '0};
	endtask

	task automatic idle_cycles(input int n);
		clear_requests();
		repeat (n) step();
	endtask

	task automatic finish_test(input string name);
		// One idle cycle lets the last responses of the test be checked.
		idle_cycles(1);
		tests_run++;
		if (test_errors == 0) begin
			$display("%-24s ok", name);
		end else begin
			$display("%-24s %0d mismatches", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	task automatic random_traffic(input int cycles, input int addr_span, input bit writes_only);
		logic [1:0] c;
		for (int i = 0; i < cycles; i++) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				c = writes_only ? 2'd2 : 2'($urandom % 3);
				next_req[p].cmd   = port_cmd_t'(c);
				next_req[p].addr  = ADDR_BITS'($urandom % addr_span);
				next_req[p].wdata = $urandom;
			end
			step();
		end
	endtask

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD * 2);
		$display("Watchdog expired after %0d ns, the tests did not finish.",
			TOTAL_CYCLES * CLK_PERIOD * 2);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(57));
		rst_n = 1'b0;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < MEM_DEPTH; i++) begin
			model[i] = '0;
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			exp_valid[p] = 1'b0;
			exp_data[p] = '0;
		end
		clear_requests();
		req_0 = next_req[0];
		req_1 = next_req[1];
		req_2 = next_req[2];
		req_3 = next_req[3];
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		idle_cycles(4);
		for (int p = 0; p < NUM_PORTS; p++) set_read(p, p);
		step();
		for (int p = 0; p < NUM_PORTS; p++) set_read(p, 60 + p);
		step();
		finish_test("reset_defaults");

		clear_requests();
		set_write(0, 5, 32'h1234_5678);
		step();
		for (int p = 0; p < NUM_PORTS; p++) begin
			clear_requests();
			set_read(p, 5);
			step();
		end
		finish_test("single_port_write_read");

		// Ascending and then descending writer order on two addresses.
		for (int w = 0; w < 2 * NUM_PORTS; w++) begin
			clear_requests();
			set_write((w < NUM_PORTS) ? w : 2 * NUM_PORTS - 1 - w, 9 + w / NUM_PORTS,
				32'hA000_0000 + w);
			step();
			for (int p = 0; p < NUM_PORTS; p++) set_read(p, 9 + w / NUM_PORTS);
			step();
		end
		finish_test("cross_port_latest_writer");

		clear_requests();
		for (int p = 0; p < NUM_PORTS; p++) set_write(p, 12, 32'hC000_0000 + p);
		step();
		for (int p = 0; p < NUM_PORTS; p++) set_read(p, 12);
		step();
		clear_requests();
		set_write(0, 13, 32'hD000_0000);
		set_write(1, 13, 32'hD000_0001);
		set_write(2, 13, 32'hD000_0002);
		step();
		for (int p = 0; p < NUM_PORTS; p++) set_read(p, 13);
		step();
		clear_requests();
		set_write(1, 12, 32'hE000_0001);
		set_write(3, 12, 32'hE000_0003);
		step();
		for (int p = 0; p < NUM_PORTS; p++) set_read(p, 12);
		step();
		finish_test("same_cycle_conflict");

		random_traffic(8, 4, 1'b1);
		finish_test("write_forwarding");

		random_traffic(RANDOM_CYCLES, 8, 1'b0);
		finish_test("random_mixed_traffic");

		$display("Tests run %0d, tests with mismatches %0d, mismatches %0d.",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* verilog/bank_array.sv */
`timescale 1ns/10ps

module bank_array import mpram_pkg::*; (
	input  logic     clock,
	input  wr_bus_t  wr_bus,
	input  rd_bus_t  rd_bus,
	// Indexed as [bank][read port].
	output logic [NUM_PORTS-1:0][NUM_PORTS-1:0][DATA_BITS-1:0] bank_rdata
);

	for (genvar b = 0; b < NUM_PORTS; b++) begin : g_bank

		// Each bank stands for a set of replicated two-port RAMs that share
		// one write port and give one read port per accelerator.
		logic [DATA_BITS-1:0] mem [MEM_DEPTH];

		// Simulation starts with every word at zero.
		initial begin
			for (int i = 0; i < MEM_DEPTH; i++) begin
				mem[i] = '0;
			end
		end

		// Only the owning port ever writes this bank.
		always @(posedge clock) begin
			if (wr_bus.en[b]) begin
				mem[wr_bus.addr[b]] <= wr_bus.wdata[b];
			end
		end

		// Registered reads. A port that writes its own bank gets the new
		// word on its own read port, so the write returns its data next
		// cycle. Every other read port sees the old word.
		always_ff @(posedge clock) begin
			for (int r = 0; r < NUM_PORTS; r++) begin
				if (r == b && wr_bus.en[b]) begin
					bank_rdata[b][r] <= wr_bus.wdata[b];
				end else begin
					bank_rdata[b][r] <= mem[rd_bus.addr[r]];
				end
			end
		end

	end

endmodule

/* verilog/live_value_table.sv */
`timescale 1ns/10ps

module live_value_table import mpram_pkg::*; (
	input  logic      clock,
	input  wr_bus_t   wr_bus,
	input  rd_bus_t   rd_bus,
	output port_id_t  selector_0,
	output port_id_t  selector_1,
	output port_id_t  selector_2,
	output port_id_t  selector_3
);

	// One entry per address, holding the port that wrote it last.
	port_id_t lvt [MEM_DEPTH];
	port_id_t selector [NUM_PORTS];

	// A write that no higher port overrides in the same cycle.
	logic [NUM_PORTS-1:0] wr_wins;

	// All words start out owned by port 0, whose bank also starts at zero.
	initial begin
		for (int i = 0; i < MEM_DEPTH; i++) begin
			lvt[i] = '0;
		end
	end

	// Ports are visited in ascending order, so when several write one
	// address in the same cycle the last assignment (highest port) sticks.
	always @(posedge clock) begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (wr_bus.en[p]) begin
				lvt[wr_bus.addr[p]] <= port_id_t'(p);
			end
		end
	end

	// A writing port must see its own data back next cycle, so its
	// selector points at its own bank rather than at the table entry.
	always_ff @(posedge clock) begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (wr_bus.en[p]) begin
				selector[p] <= port_id_t'(p);
			end else begin
				selector[p] <= lvt[rd_bus.addr[p]];
			end
		end
	end

	assign selector_0 = selector[0];
	assign selector_1 = selector[1];
	assign selector_2 = selector[2];
	assign selector_3 = selector[3];

	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			wr_wins[p] = wr_bus.en[p];
			for (int q = p + 1; q < NUM_PORTS; q++) begin
				if (wr_bus.en[q] && wr_bus.addr[q] == wr_bus.addr[p]) begin
					wr_wins[p] = 1'b0;
				end
			end
		end
	end

	// The winning writer of an address must own its table entry afterwards.
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_owner_check
		a_table_owner: assert property (
			@(posedge clock)
			wr_wins[p] |=> (lvt[$past(wr_bus.addr[p])] == port_id_t'(p))
		) else $error("port %0d does not own the address it wrote", p);
	end

endmodule

/* verilog/mpram_4w4r.sv */
`timescale 1ns/10ps

module mpram_4w4r import mpram_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	input  port_req_t  req_0,
	input  port_req_t  req_1,
	input  port_req_t  req_2,
	input  port_req_t  req_3,
	output port_rsp_t  rsp_0,
	output port_rsp_t  rsp_1,
	output port_rsp_t  rsp_2,
	output port_rsp_t  rsp_3
);

	wr_bus_t               wr_bus;
	rd_bus_t               rd_bus;
	logic [NUM_PORTS-1:0]  rsp_pending;
	port_id_t              selector_0;
	port_id_t              selector_1;
	port_id_t              selector_2;
	port_id_t              selector_3;

	logic [NUM_PORTS-1:0][NUM_PORTS-1:0][DATA_BITS-1:0] bank_rdata;

	port_decode u_port_decode (
		.clock       (clock),
		.rst_n       (rst_n),
		.req_0       (req_0),
		.req_1       (req_1),
		.req_2       (req_2),
		.req_3       (req_3),
		.wr_bus      (wr_bus),
		.rd_bus      (rd_bus),
		.rsp_pending (rsp_pending)
	);

	bank_array u_bank_array (
		.clock      (clock),
		.wr_bus     (wr_bus),
		.rd_bus     (rd_bus),
		.bank_rdata (bank_rdata)
	);

	// The table and the banks both update at the same edge, so selector
	// and bank word arrive together in the response cycle.
	live_value_table u_live_value_table (
		.clock      (clock),
		.wr_bus     (wr_bus),
		.rd_bus     (rd_bus),
		.selector_0 (selector_0),
		.selector_1 (selector_1),
		.selector_2 (selector_2),
		.selector_3 (selector_3)
	);

	read_select u_read_select (
		.bank_rdata  (bank_rdata),
		.selector_0  (selector_0),
		.selector_1  (selector_1),
		.selector_2  (selector_2),
		.selector_3  (selector_3),
		.rsp_pending (rsp_pending),
		.rsp_0       (rsp_0),
		.rsp_1       (rsp_1),
		.rsp_2       (rsp_2),
		.rsp_3       (rsp_3)
	);

endmodule

/* verilog/mpram_pkg.sv */
package mpram_pkg;

	// Geometry of the shared cache memory.
	localparam int NUM_PORTS = 4;
	localparam int ADDR_BITS = 6;
	localparam int MEM_DEPTH = 64;
	localparam int DATA_BITS = 32;

	// One live value table entry names the port that last wrote a word.
	typedef logic [1:0] port_id_t;

	typedef enum logic [1:0] {
		CMD_IDLE  = 2'd0,
		CMD_READ  = 2'd1,
		CMD_WRITE = 2'd2
	} port_cmd_t;

	// A request from one accelerator, at most one per cycle.
	typedef struct packed {
		port_cmd_t             cmd;
		logic [ADDR_BITS-1:0]  addr;
		logic [DATA_BITS-1:0]  wdata;
	} port_req_t;

	// The response comes back as a one-cycle valid pulse.
	typedef struct packed {
		logic                  rvalid;
		logic [DATA_BITS-1:0]  rdata;
	} port_rsp_t;

	typedef struct packed {
		logic [NUM_PORTS-1:0]                 en;
		logic [NUM_PORTS-1:0][ADDR_BITS-1:0]  addr;
		logic [NUM_PORTS-1:0][DATA_BITS-1:0]  wdata;
	} wr_bus_t;

	typedef struct packed {
		logic [NUM_PORTS-1:0][ADDR_BITS-1:0]  addr;
	} rd_bus_t;

endpackage

/* verilog/port_decode.sv */
`timescale 1ns/10ps

module port_decode import mpram_pkg::*; (
	input  logic                  clock,
	input  logic                  rst_n,
	input  port_req_t             req_0,
	input  port_req_t             req_1,
	input  port_req_t             req_2,
	input  port_req_t             req_3,
	output wr_bus_t               wr_bus,
	output rd_bus_t               rd_bus,
	output logic [NUM_PORTS-1:0]  rsp_pending
);

	port_req_t req [NUM_PORTS];

	assign req[0] = req_0;
	assign req[1] = req_1;
	assign req[2] = req_2;
	assign req[3] = req_3;

	// Write strobes leave in the same cycle as the request.
	// The request address serves both the write and the read side, since a
	// port issues only one command per cycle.
	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			wr_bus.en[p]    = (req[p].cmd == CMD_WRITE);
			wr_bus.addr[p]  = req[p].addr;
			wr_bus.wdata[p] = req[p].wdata;
			rd_bus.addr[p]  = req[p].addr;
		end
	end

	// Every non-idle command owes a response one cycle later.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rsp_pending <= '0;
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				rsp_pending[p] <= (req[p].cmd != CMD_IDLE);
			end
		end
	end

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_cmd_check
		a_legal_cmd: assert property (
			@(posedge clock) disable iff (!rst_n)
			req[p].cmd inside {CMD_IDLE, CMD_READ, CMD_WRITE}
		) else $error("port %0d issued unknown command %0h", p, req[p].cmd);
	end

endmodule

/* verilog/read_select.sv */
`timescale 1ns/10ps

module read_select import mpram_pkg::*; (
	input  logic [NUM_PORTS-1:0][NUM_PORTS-1:0][DATA_BITS-1:0] bank_rdata,
	input  port_id_t              selector_0,
	input  port_id_t              selector_1,
	input  port_id_t              selector_2,
	input  port_id_t              selector_3,
	input  logic [NUM_PORTS-1:0]  rsp_pending,
	output port_rsp_t             rsp_0,
	output port_rsp_t             rsp_1,
	output port_rsp_t             rsp_2,
	output port_rsp_t             rsp_3
);

	port_id_t  selector [NUM_PORTS];
	port_rsp_t rsp [NUM_PORTS];

	assign selector[0] = selector_0;
	assign selector[1] = selector_1;
	assign selector[2] = selector_2;
	assign selector[3] = selector_3;

	// Read port p takes its word from the bank its selector names.
	// Data stays at zero outside the valid pulse.
	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			rsp[p].rvalid = rsp_pending[p];
			if (rsp_pending[p]) begin
				rsp[p].rdata = bank_rdata[selector[p]][p];
			end else begin
				rsp[p].rdata = '0;
			end
		end
	end

	assign rsp_0 = rsp[0];
	assign rsp_1 = rsp[1];
	assign rsp_2 = rsp[2];
	assign rsp_3 = rsp[3];

endmodule
